// File: hw/lsu_pkg.sv
package lsu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int XLEN_W     = 64;
  localparam int ADDR_W     = 40;
  localparam int LINE_BYTES = 16;
  localparam int DW_BYTES   = 8;

  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_DW
  } size_e;

  typedef enum logic {
    SIGN_U,
    SIGN_S
  } sign_e;

  typedef enum logic [1:0] {
    ST_NONE,
    ST_L1D_MISS,
    ST_MISALIGN
  } lsu_status_e;

  typedef struct packed {
    logic       is_load;
    size_e      size;
    sign_e      sign;
    logic [3:0] tag;
  } lsu_op_t;

  // EX1 input, straight from the issue port
  typedef struct packed {
    lsu_op_t           op;
    logic [XLEN_W-1:0] base;
    logic [11:0]       imm;
    logic [XLEN_W-1:0] st_data;
  } ex1_payload_t;

  typedef struct packed {
    lsu_op_t           op;
    logic [ADDR_W-1:0] paddr;
    logic              misalign;
    logic [XLEN_W-1:0] st_data;
  } ex2_payload_t;

  typedef struct packed {
    logic [3:0]          tag;
    lsu_status_e         status;
    logic [ADDR_W-1:0]   paddr;
    logic [DW_BYTES-1:0] byte_mask;
    logic [XLEN_W-1:0]   data;
  } ex3_payload_t;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Bytes touched inside the doubleword; spill past byte 7 is dropped
  function automatic logic [DW_BYTES-1:0] gen_byte_mask(size_e size, logic [2:0] offset);
    logic [DW_BYTES-1:0] base_mask;
    case (size)
      SIZE_B:  base_mask = 8'h01;
      SIZE_H:  base_mask = 8'h03;
      SIZE_W:  base_mask = 8'h0f;
      default: base_mask = 8'hff;
    endcase
    return base_mask << offset;
  endfunction

  function automatic logic is_misaligned(size_e size, logic [2:0] offset);
    logic result;
    case (size)
      SIZE_H:  result = offset[0];
      SIZE_W:  result = |offset[1:0];
      SIZE_DW: result = |offset;
      default: result = 1'b0;
    endcase
    return result;
  endfunction

endpackage

// File: hw/lsu_stage_reg.sv
`timescale 1ns/1ps

module lsu_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_reset_n,

  // Upstream
  input  logic     i_valid,
  input  payload_t i_payload,
  output logic     o_ready,

  // Downstream
  output logic     o_valid,
  output payload_t o_payload,
  input  logic     i_ready
);

  logic     r_valid;
  payload_t r_payload;
  logic     w_load;

  // Free slot, or the held item leaves this cycle
  assign o_ready = !r_valid || i_ready;
  assign w_load  = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (o_ready) begin
      r_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_payload <= i_payload;
    end
  end

  assign o_valid   = r_valid;
  assign o_payload = r_payload;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Stalled item must stay put until the consumer takes it
  property p_hold_stable;
    @(posedge i_clk) disable iff (!i_reset_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_payload));
  endproperty

  a_hold_stable: assert property (p_hold_stable)
    else $error("lsu_stage_reg: payload changed while stalled");

endmodule

// File: hw/lsu_agen.sv
`timescale 1ns/1ps

module lsu_agen (
  // EX1 item
  input  logic                        i_valid,
  input  logic                        i_advance,
  input  lsu_pkg::ex1_payload_t       i_payload,

  // Towards EX2
  output lsu_pkg::ex2_payload_t       o_payload,

  // L1D read request
  output logic                        o_l1d_req_valid,
  output logic [lsu_pkg::ADDR_W-1:0]  o_l1d_req_paddr
);

  import lsu_pkg::*;

  localparam int LINE_OFS_W = $clog2(LINE_BYTES);

  logic [ADDR_W-1:0] w_imm_ext;
  logic [ADDR_W-1:0] w_paddr;
  logic              w_misalign;

  // --------------------------------------------------------------------------
  // Address
  // --------------------------------------------------------------------------
  // No translation, the sum is the physical address
  assign w_imm_ext  = {{(ADDR_W-12){i_payload.imm[11]}}, i_payload.imm};
  assign w_paddr    = i_payload.base[ADDR_W-1:0] + w_imm_ext;
  assign w_misalign = is_misaligned(i_payload.op.size, w_paddr[2:0]);

  always_comb begin
    o_payload          = '0;
    o_payload.op       = i_payload.op;
    o_payload.paddr    = w_paddr;
    o_payload.misalign = w_misalign;
    o_payload.st_data  = i_payload.st_data;
  end

  // --------------------------------------------------------------------------
  // Cache request
  // --------------------------------------------------------------------------
  // Fires only on the cycle the load moves to EX2,
  // so the response lines up with its first EX2 cycle
  assign o_l1d_req_valid = i_valid && i_advance && i_payload.op.is_load && !w_misalign;
  assign o_l1d_req_paddr = {w_paddr[ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};

endmodule

// File: hw/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align (
  input  logic [lsu_pkg::LINE_BYTES*8-1:0] i_line,
  input  logic [3:0]                       i_paddr_low,
  input  lsu_pkg::size_e                   i_size,
  input  lsu_pkg::sign_e                   i_sign,

  // Store queue answer, in doubleword lanes
  input  logic [lsu_pkg::DW_BYTES-1:0]     i_fwd_byte_mask,
  input  logic [lsu_pkg::XLEN_W-1:0]       i_fwd_data,

  output logic [lsu_pkg::XLEN_W-1:0]       o_data,
  output logic                             o_covered
);

  import lsu_pkg::*;

  logic [XLEN_W-1:0]   w_dw;
  logic [XLEN_W-1:0]   w_merged;
  logic [XLEN_W-1:0]   w_shifted;
  logic [DW_BYTES-1:0] w_need_mask;
  logic [2:0]          w_offset;

  assign w_offset = i_paddr_low[2:0];

  // --------------------------------------------------------------------------
  // Doubleword select and merge
  // --------------------------------------------------------------------------
  // Bit 3 picks the half of the 16-byte line
  assign w_dw = i_line[i_paddr_low[3]*XLEN_W +: XLEN_W];

  for (genvar b = 0; b < DW_BYTES; b++) begin : g_merge
    assign w_merged[b*8 +: 8] = i_fwd_byte_mask[b] ? i_fwd_data[b*8 +: 8]
                                                   : w_dw[b*8 +: 8];
  end

  // Every needed byte came from the store queue
  assign w_need_mask = gen_byte_mask(i_size, w_offset);
  assign o_covered   = ((w_need_mask & ~i_fwd_byte_mask) == '0);

  // --------------------------------------------------------------------------
  // Shift down and extend
  // --------------------------------------------------------------------------
  assign w_shifted = w_merged >> {w_offset, 3'b000};

  always_comb begin
    case (i_size)
      SIZE_B: begin
        if (i_sign == SIGN_S) begin
          o_data = {{(XLEN_W-8){w_shifted[7]}}, w_shifted[7:0]};
        end else begin
          o_data = {{(XLEN_W-8){1'b0}}, w_shifted[7:0]};
        end
      end
      SIZE_H: begin
        if (i_sign == SIGN_S) begin
          o_data = {{(XLEN_W-16){w_shifted[15]}}, w_shifted[15:0]};
        end else begin
          o_data = {{(XLEN_W-16){1'b0}}, w_shifted[15:0]};
        end
      end
      SIZE_W: begin
        if (i_sign == SIGN_S) begin
          o_data = {{(XLEN_W-32){w_shifted[31]}}, w_shifted[31:0]};
        end else begin
          o_data = {{(XLEN_W-32){1'b0}}, w_shifted[31:0]};
        end
      end
      default: begin
        o_data = w_shifted;
      end
    endcase
  end

endmodule

// File: hw/lsu_ex2_resolve.sv
`timescale 1ns/1ps

module lsu_ex2_resolve (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  // EX2 item
  input  logic                             i_valid,
  input  logic                             i_advance,
  input  lsu_pkg::ex2_payload_t            i_payload,

  // L1D response, one cycle after the request
  input  logic                             i_l1d_resp_hit,
  input  logic [lsu_pkg::LINE_BYTES*8-1:0] i_l1d_resp_line,

  // Store queue lookup
  output logic                             o_fwd_valid,
  output logic [lsu_pkg::ADDR_W-1:0]       o_fwd_paddr,
  output logic [lsu_pkg::DW_BYTES-1:0]     o_fwd_byte_mask,
  input  logic [lsu_pkg::DW_BYTES-1:0]     i_fwd_byte_mask,
  input  logic [lsu_pkg::XLEN_W-1:0]       i_fwd_data,

  output lsu_pkg::ex3_payload_t            o_payload
);

  import lsu_pkg::*;

  logic                    r_resp_held;
  logic                    r_hit;
  logic [LINE_BYTES*8-1:0] r_line;
  logic                    w_need_resp;
  logic                    w_capture;
  logic                    w_hit;
  logic [LINE_BYTES*8-1:0] w_line;
  logic [DW_BYTES-1:0]     w_mask;
  logic [XLEN_W-1:0]       w_ld_data;
  logic                    w_covered;

  assign w_need_resp = i_payload.op.is_load && !i_payload.misalign;
  assign w_mask      = gen_byte_mask(i_payload.op.size, i_payload.paddr[2:0]);

  // --------------------------------------------------------------------------
  // Response hold
  // --------------------------------------------------------------------------
  // Response is live only on the first EX2 cycle; keep it if EX2 stalls
  assign w_capture = i_valid && w_need_resp && !r_resp_held && !i_advance;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_held <= 1'b0;
    end else if (i_valid && i_advance) begin
      r_resp_held <= 1'b0;
    end else if (w_capture) begin
      r_resp_held <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_capture) begin
      r_hit  <= i_l1d_resp_hit;
      r_line <= i_l1d_resp_line;
    end
  end

  assign w_hit  = r_resp_held ? r_hit  : i_l1d_resp_hit;
  assign w_line = r_resp_held ? r_line : i_l1d_resp_line;

  assign o_fwd_valid     = i_valid && w_need_resp;
  assign o_fwd_paddr     = i_payload.paddr;
  assign o_fwd_byte_mask = w_mask;

  lsu_load_align u_load_align (
    .i_line          (w_line),
    .i_paddr_low     (i_payload.paddr[3:0]),
    .i_size          (i_payload.op.size),
    .i_sign          (i_payload.op.sign),
    .i_fwd_byte_mask (i_fwd_byte_mask),
    .i_fwd_data      (i_fwd_data),
    .o_data          (w_ld_data),
    .o_covered       (w_covered)
  );

  // --------------------------------------------------------------------------
  // Result
  // --------------------------------------------------------------------------
  always_comb begin
    o_payload           = '0;
    o_payload.tag       = i_payload.op.tag;
    o_payload.paddr     = i_payload.paddr;
    if (i_payload.misalign) begin
      o_payload.status = ST_MISALIGN;
    end else if (i_payload.op.is_load) begin
      // Full forwarding hides a cache miss
      o_payload.status    = (!w_hit && !w_covered) ? ST_L1D_MISS : ST_NONE;
      o_payload.byte_mask = w_mask;
      o_payload.data      = w_ld_data;
    end else begin
      o_payload.status    = ST_NONE;
      o_payload.byte_mask = w_mask;
      o_payload.data      = i_payload.st_data << {i_payload.paddr[2:0], 3'b000};
    end
  end

  // Capture only on the first EX2 cycle, right after the EX1 request
  a_capture_after_req: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      w_capture |-> $past(!i_valid || i_advance)
  ) else $error("lsu_ex2_resolve: response captured with no request in flight");

endmodule

// File: hw/lsu_pipe.sv
`timescale 1ns/1ps

module lsu_pipe (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  // Issue port
  input  logic                             i_issue_valid,
  output logic                             o_issue_ready,
  input  lsu_pkg::lsu_op_t                 i_issue_op,
  input  logic [lsu_pkg::XLEN_W-1:0]       i_issue_base,
  input  logic [11:0]                      i_issue_imm,
  input  logic [lsu_pkg::XLEN_W-1:0]       i_issue_st_data,

  // L1D port
  output logic                             o_l1d_req_valid,
  output logic [lsu_pkg::ADDR_W-1:0]       o_l1d_req_paddr,
  input  logic                             i_l1d_resp_hit,
  input  logic [lsu_pkg::LINE_BYTES*8-1:0] i_l1d_resp_line,

  // Store queue forwarding
  output logic                             o_fwd_valid,
  output logic [lsu_pkg::ADDR_W-1:0]       o_fwd_paddr,
  output logic [lsu_pkg::DW_BYTES-1:0]     o_fwd_byte_mask,
  input  logic [lsu_pkg::DW_BYTES-1:0]     i_fwd_byte_mask,
  input  logic [lsu_pkg::XLEN_W-1:0]       i_fwd_data,

  // Result port
  output logic                             o_res_valid,
  input  logic                             i_res_ready,
  output logic [3:0]                       o_res_tag,
  output lsu_pkg::lsu_status_e             o_res_status,
  output logic [lsu_pkg::ADDR_W-1:0]       o_res_paddr,
  output logic [lsu_pkg::DW_BYTES-1:0]     o_res_byte_mask,
  output logic [lsu_pkg::XLEN_W-1:0]       o_res_data
);

  import lsu_pkg::*;

  ex1_payload_t w_ex1_in;
  ex1_payload_t w_ex1_payload;
  logic         w_ex1_valid;
  ex2_payload_t w_ex2_in;
  ex2_payload_t w_ex2_payload;
  logic         w_ex2_valid;
  logic         w_ex2_ready;
  ex3_payload_t w_ex3_in;
  ex3_payload_t w_ex3_payload;
  logic         w_ex3_ready;

  assign w_ex1_in = '{op: i_issue_op, base: i_issue_base, imm: i_issue_imm,
                      st_data: i_issue_st_data};

  // --------------------------------------------------------------------------
  // EX1 address generation
  // --------------------------------------------------------------------------
  lsu_stage_reg #(.payload_t(ex1_payload_t)) u_ex1_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_issue_valid),
    .i_payload (w_ex1_in),
    .o_ready   (o_issue_ready),
    .o_valid   (w_ex1_valid),
    .o_payload (w_ex1_payload),
    .i_ready   (w_ex2_ready)
  );

  lsu_agen u_agen (
    .i_valid         (w_ex1_valid),
    .i_advance       (w_ex2_ready),
    .i_payload       (w_ex1_payload),
    .o_payload       (w_ex2_in),
    .o_l1d_req_valid (o_l1d_req_valid),
    .o_l1d_req_paddr (o_l1d_req_paddr)
  );

  // --------------------------------------------------------------------------
  // EX2 cache data, forwarding and status
  // --------------------------------------------------------------------------
  lsu_stage_reg #(.payload_t(ex2_payload_t)) u_ex2_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_ex1_valid),
    .i_payload (w_ex2_in),
    .o_ready   (w_ex2_ready),
    .o_valid   (w_ex2_valid),
    .o_payload (w_ex2_payload),
    .i_ready   (w_ex3_ready)
  );

  lsu_ex2_resolve u_ex2_resolve (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (w_ex2_valid),
    .i_advance       (w_ex3_ready),
    .i_payload       (w_ex2_payload),
    .i_l1d_resp_hit  (i_l1d_resp_hit),
    .i_l1d_resp_line (i_l1d_resp_line),
    .o_fwd_valid     (o_fwd_valid),
    .o_fwd_paddr     (o_fwd_paddr),
    .o_fwd_byte_mask (o_fwd_byte_mask),
    .i_fwd_byte_mask (i_fwd_byte_mask),
    .i_fwd_data      (i_fwd_data),
    .o_payload       (w_ex3_in)
  );

  // EX3 result buffer
  lsu_stage_reg #(.payload_t(ex3_payload_t)) u_ex3_reg (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_ex2_valid),
    .i_payload (w_ex3_in),
    .o_ready   (w_ex3_ready),
    .o_valid   (o_res_valid),
    .o_payload (w_ex3_payload),
    .i_ready   (i_res_ready)
  );

  assign o_res_tag       = w_ex3_payload.tag;
  assign o_res_status    = w_ex3_payload.status;
  assign o_res_paddr     = w_ex3_payload.paddr;
  assign o_res_byte_mask = w_ex3_payload.byte_mask;
  assign o_res_data      = w_ex3_payload.data;

endmodule

// File: verification/lsu_pipe_tb.sv
`timescale 1ns/1ps

module lsu_pipe_tb;

  import lsu_pkg::*;

  localparam int  MAX_VEC        = 64;
  localparam int  TIMEOUT_CYCLES = 200;
  localparam time CLK_PERIOD     = 100ns;
  localparam time DRIVE_DLY      = 10ns;

  logic                    clk;
  logic                    reset_n;
  logic                    issue_valid;
  logic                    issue_ready;
  lsu_op_t                 issue_op;
  logic [XLEN_W-1:0]       issue_base;
  logic [11:0]             issue_imm;
  logic [XLEN_W-1:0]       issue_st_data;
  logic                    l1d_req_valid;
  logic [ADDR_W-1:0]       l1d_req_paddr;
  logic                    l1d_resp_hit;
  logic [LINE_BYTES*8-1:0] l1d_resp_line;
  logic                    fwd_valid;
  logic [ADDR_W-1:0]       fwd_paddr;
  logic [DW_BYTES-1:0]     fwd_req_mask;
  logic [DW_BYTES-1:0]     fwd_resp_mask;
  logic [XLEN_W-1:0]       fwd_resp_data;
  logic                    res_valid;
  logic                    res_ready;
  logic [3:0]              res_tag;
  lsu_status_e             res_status;
  logic [ADDR_W-1:0]       res_paddr;
  logic [DW_BYTES-1:0]     res_byte_mask;
  logic [XLEN_W-1:0]       res_data;

  // One entry per operation in each vector column
  logic                    v_is_load    [MAX_VEC];
  logic [1:0]              v_size       [MAX_VEC];
  logic                    v_sign       [MAX_VEC];
  logic [3:0]              v_tag        [MAX_VEC];
  logic [XLEN_W-1:0]       v_base       [MAX_VEC];
  logic [11:0]             v_imm        [MAX_VEC];
  logic [XLEN_W-1:0]       v_st_data    [MAX_VEC];
  logic                    v_hit        [MAX_VEC];
  logic [LINE_BYTES*8-1:0] v_line       [MAX_VEC];
  logic [DW_BYTES-1:0]     v_fwd_mask   [MAX_VEC];
  logic [XLEN_W-1:0]       v_fwd_data   [MAX_VEC];
  logic [1:0]              v_exp_status [MAX_VEC];
  logic [DW_BYTES-1:0]     v_exp_mask   [MAX_VEC];
  logic [XLEN_W-1:0]       v_exp_data   [MAX_VEC];

  int vec_count         = 0;
  int seed              = 32'h6e0d;
  int cycle_cnt         = 0;
  int error_count       = 0;
  int test_count        = 0;
  int fail_count        = 0;
  int cur_issue_idx     = 0;
  int first_issue_cycle = -1;
  int resp_idx          = 0;
  int fwd_idx           = 0;
  bit latency_pending   = 1'b0;
  bit stall_round       = 1'b0;
  bit timed_out         = 1'b0;
  bit resp_pending      = 1'b0;
  int exp_q[$];
  int req_q[$];

  lsu_pipe DUT (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_issue_valid   (issue_valid),
    .o_issue_ready   (issue_ready),
    .i_issue_op      (issue_op),
    .i_issue_base    (issue_base),
    .i_issue_imm     (issue_imm),
    .i_issue_st_data (issue_st_data),
    .o_l1d_req_valid (l1d_req_valid),
    .o_l1d_req_paddr (l1d_req_paddr),
    .i_l1d_resp_hit  (l1d_resp_hit),
    .i_l1d_resp_line (l1d_resp_line),
    .o_fwd_valid     (fwd_valid),
    .o_fwd_paddr     (fwd_paddr),
    .o_fwd_byte_mask (fwd_req_mask),
    .i_fwd_byte_mask (fwd_resp_mask),
    .i_fwd_data      (fwd_resp_data),
    .o_res_valid     (res_valid),
    .i_res_ready     (res_ready),
    .o_res_tag       (res_tag),
    .o_res_status    (res_status),
    .o_res_paddr     (res_paddr),
    .o_res_byte_mask (res_byte_mask),
    .o_res_data      (res_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Physical address is base plus the sign-extended immediate
  function automatic logic [ADDR_W-1:0] calc_paddr(input int idx);
    logic [ADDR_W-1:0] imm_ext;
    imm_ext = {{(ADDR_W-12){v_imm[idx][11]}}, v_imm[idx]};
    return v_base[idx][ADDR_W-1:0] + imm_ext;
  endfunction

  task automatic check_field(input string name, input logic [63:0] expected,
                             input logic [63:0] actual, inout bit ok);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
      ok = 1'b0;
    end
  endtask

  task automatic check_result(input int idx);
    bit ok;
    ok = 1'b1;
    check_field("o_res_tag", v_tag[idx], res_tag, ok);
    check_field("o_res_status", v_exp_status[idx], res_status, ok);
    check_field("o_res_paddr", calc_paddr(idx), res_paddr, ok);
    check_field("o_res_byte_mask", v_exp_mask[idx], res_byte_mask, ok);
    check_field("o_res_data", v_exp_data[idx], res_data, ok);
    test_count++;
    if (!ok) begin
      fail_count++;
    end
    $display("Test %0d round %0d vector %0d tag %h: %s", test_count, stall_round, idx,
             v_tag[idx], ok ? "ok" : "FAILED");
  endtask

  task automatic read_vectors();
    int    fd;
    int    fields;
    string text;
    fd = $fopen("verification/lsu_input_vectors.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the vector file");
      error_count++;
    end
    while (fd != 0 && !$feof(fd) && vec_count < MAX_VEC) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() > 1 && text.getc(0) != "#") begin
        fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         v_is_load[vec_count], v_size[vec_count], v_sign[vec_count],
                         v_tag[vec_count], v_base[vec_count], v_imm[vec_count],
                         v_st_data[vec_count], v_hit[vec_count], v_line[vec_count],
                         v_fwd_mask[vec_count], v_fwd_data[vec_count],
                         v_exp_status[vec_count], v_exp_mask[vec_count],
                         v_exp_data[vec_count]);
        assert (fields == 14) else begin
          $display("Malformed vector line: %s", text);
          error_count++;
        end
        if (fields == 14) begin
          vec_count++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    assert (vec_count > 0) else begin
      $display("The vector file holds no operations");
      error_count++;
    end
  endtask

  // Called 10 ns after a rising edge; returns at the same phase
  task automatic issue_one(input int idx);
    int waited;
    waited        = 0;
    cur_issue_idx = idx;
    issue_op      = '{is_load: v_is_load[idx], size: size_e'(v_size[idx]),
                      sign: sign_e'(v_sign[idx]), tag: v_tag[idx]};
    issue_base    = v_base[idx];
    issue_imm     = v_imm[idx];
    issue_st_data = v_st_data[idx];
    issue_valid   = 1'b1;
    @(negedge clk);
    while (!issue_ready && waited < TIMEOUT_CYCLES) begin
      waited++;
      @(negedge clk);
    end
    if (!issue_ready) begin
      $display("Timeout: vector %0d was never accepted on the issue port", idx);
      timed_out = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic run_round();
    for (int i = 0; i < vec_count && !timed_out; i++) begin
      issue_one(i);
    end
    issue_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES);
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d results never left the result port", exp_q.size());
      timed_out = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Cache, store queue and result models
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    #DRIVE_DLY;
    if (stall_round) begin
      res_ready = ($random(seed) & 32'h1) != 0;
    end else begin
      res_ready = 1'b1;
    end
  end

  // Line is valid only in the cycle after the request
  always @(posedge clk) begin
    #DRIVE_DLY;
    if (resp_pending) begin
      l1d_resp_hit  = v_hit[resp_idx];
      l1d_resp_line = v_line[resp_idx];
      fwd_idx       = resp_idx;
      resp_pending  = 1'b0;
    end else begin
      l1d_resp_hit  = 1'b0;
      l1d_resp_line = {4{cycle_cnt ^ 32'h5a5a_c3c3}};
    end
  end

  // The load in EX2 is always the one that made the last request
  assign fwd_resp_mask = fwd_valid ? (v_fwd_mask[fwd_idx] & fwd_req_mask) : '0;
  assign fwd_resp_data = v_fwd_data[fwd_idx];

  always @(negedge clk) begin
    int                idx;
    bit                ok;
    logic [ADDR_W-1:0] line_addr;
    if (reset_n) begin
      ok = 1'b1;
      // Handshake cycle plus three
      if (latency_pending && res_valid) begin
        check_field("o_res_valid latency", 64'd3, 64'(cycle_cnt - first_issue_cycle), ok);
        latency_pending = 1'b0;
      end
      if (res_valid && res_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("Result at %0t arrived with no operation outstanding", $time);
          error_count++;
        end
        if (exp_q.size() != 0) begin
          idx = exp_q.pop_front();
          check_result(idx);
        end
      end
      if (l1d_req_valid) begin
        assert (req_q.size() != 0) else begin
          $display("Cache request at %0t with no aligned load waiting for one", $time);
          error_count++;
        end
        if (req_q.size() != 0) begin
          idx             = req_q.pop_front();
          line_addr       = calc_paddr(idx);
          line_addr[3:0]  = 4'h0;
          check_field("o_l1d_req_paddr", line_addr, l1d_req_paddr, ok);
          resp_idx        = idx;
          resp_pending    = 1'b1;
        end
      end
      if (fwd_valid) begin
        check_field("o_fwd_paddr", calc_paddr(fwd_idx), fwd_paddr, ok);
        check_field("o_fwd_byte_mask", v_exp_mask[fwd_idx], fwd_req_mask, ok);
      end
      if (issue_valid && issue_ready) begin
        exp_q.push_back(cur_issue_idx);
        if (v_is_load[cur_issue_idx] && v_exp_status[cur_issue_idx] != 2'd2) begin
          req_q.push_back(cur_issue_idx);
        end
        if (first_issue_cycle < 0) begin
          first_issue_cycle = cycle_cnt;
          latency_pending   = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    reset_n       = 1'b0;
    issue_valid   = 1'b0;
    issue_op      = '0;
    issue_base    = '0;
    issue_imm     = '0;
    issue_st_data = '0;
    l1d_resp_hit  = 1'b0;
    l1d_resp_line = '0;
    res_ready     = 1'b1;
    read_vectors();
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    assert (!res_valid && !l1d_req_valid && !fwd_valid) else begin
      $display("Valid outputs are not low during reset");
      error_count++;
    end
    reset_n = 1'b1;

    // First round runs with the result port always ready
    run_round();
    if (!timed_out) begin
      wait_drain();
    end
    stall_round = 1'b1;
    if (!timed_out) begin
      #DRIVE_DLY;
      run_round();
      wait_drain();
    end
    assert (req_q.size() == 0) else begin
      $display("%0d aligned loads never sent a cache request", req_q.size());
      error_count++;
    end

    $display("Tests: %0d, failed: %0d, errors: %0d", test_count, fail_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: build.f
hw/lsu_pkg.sv
hw/lsu_stage_reg.sv
hw/lsu_agen.sv
hw/lsu_load_align.sv
hw/lsu_ex2_resolve.sv
hw/lsu_pipe.sv
verification/lsu_pipe_tb.sv

// File: Bender.yml
package:
  name: lsu_pipe

dependencies: {}

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/lsu_stage_reg.sv
      - hw/lsu_agen.sv
      - hw/lsu_load_align.sv
      - hw/lsu_ex2_resolve.sv
      - hw/lsu_pipe.sv

  - target: test
    files:
      - verification/lsu_pipe_tb.sv

// File: verification/lsu_input_vectors.txt
# is_load size sign tag base imm st_data hit line fwd_mask fwd_data exp_status exp_mask exp_data
# all hex; size 0=B 1=H 2=W 3=DW, sign 1=signed, status 0=none 1=miss 2=misalign
1 0 1 1 0000000080001000 008 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 01 ffffffffffffff80
1 0 0 2 0000000080001000 00f 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 80 00000000000000f7
1 0 1 3 0000000080001000 005 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 20 000000000000005d
1 1 1 4 0000000080001000 00a 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 0c ffffffffffffb3a2
1 1 0 5 0000000080001000 004 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 30 0000000000005d4c
1 1 0 6 0000000080001000 00e 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 c0 000000000000f7e6
1 2 1 7 0000000080001000 00c 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 f0 fffffffff7e6d5c4
1 2 0 8 0000000080001010 ffc 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 f0 00000000f7e6d5c4
1 3 0 9 0000000080001000 000 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 ff 7f6e5d4c3b2a1908
1 3 0 a 0000000080001000 008 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 ff f7e6d5c4b3a29180
1 0 0 b 0000000080001000 001 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 0 02 0000000000000019
0 0 0 c 0000000080001000 003 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 0 08 4455667788000000
0 1 0 d 0000000080001000 006 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 0 c0 7788000000000000
0 2 0 e 0000000080001000 004 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 0 f0 5566778800000000
0 3 0 f 0000000080001000 008 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 0 ff 1122334455667788
1 1 1 0 0000000080001000 001 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 2 00 0000000000000000
1 2 0 1 0000000080001000 006 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 2 00 0000000000000000
1 3 0 2 0000000080001000 004 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 2 00 0000000000000000
0 2 0 3 0000000080001000 002 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 2 00 0000000000000000
0 1 0 4 0000000080001000 005 1122334455667788 0 00000000000000000000000000000000 00 0000000000000000 2 00 0000000000000000
1 3 0 5 0000000080001000 000 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 0f 00000000a1b2c3d4 0 ff 7f6e5d4ca1b2c3d4
1 2 1 6 0000000080001000 004 0000000000000000 1 f7e6d5c4b3a291807f6e5d4c3b2a1908 30 0000beef00000000 0 f0 000000007f6ebeef
1 2 0 7 0000000080001000 00c 0000000000000000 0 f7e6d5c4b3a291807f6e5d4c3b2a1908 f0 89abcdef00000000 0 f0 0000000089abcdef
1 0 1 8 0000000080001000 007 0000000000000000 0 f7e6d5c4b3a291807f6e5d4c3b2a1908 80 9a00000000000000 0 80 ffffffffffffff9a
1 1 0 9 0000000080001000 002 0000000000000000 0 f7e6d5c4b3a291807f6e5d4c3b2a1908 04 0000000000550000 1 0c 0000000000003b55
1 3 0 a 0000000080001000 008 0000000000000000 0 f7e6d5c4b3a291807f6e5d4c3b2a1908 00 0000000000000000 1 ff f7e6d5c4b3a29180
